// ==== source/game_pkg.sv ====
// game_pkg
// Match-level definitions for the penalty shootout: the player's role or
// match phase, the play mode, and the score that ends a match.

package game_pkg;

    // role of the local player, or the match phase around the rounds
    typedef enum logic [1:0] {
        IDLE    = 2'b00,  // waiting for start, scores cleared
        SHOOTER = 2'b01,  // local player kicks
        KEEPER  = 2'b10,  // local player dives
        OVER    = 2'b11   // match decided, result held
    } g_state;

    // SOLO resolves everything locally, MULTI takes the enemy side from the link
    typedef enum logic {
        SOLO  = 1'b0,
        MULTI = 1'b1
    } g_mode;

    localparam int SCORE_W = 3;  // enough for 0..5

    // first side to reach this wins
    localparam logic [SCORE_W-1:0] WIN_SCORE = 3'd5;

endpackage

// ==== source/link_pkg.sv ====
// link_pkg
// Timing of the serial link to the other board and the fixed fields
// of the status byte carried on it.

package link_pkg;

    localparam int BIT_CYCLES = 4;                   // clocks per serial bit
    localparam int FRAME_BITS = 10;                  // start, 8 data, stop
    localparam int CYC_W      = $clog2(BIT_CYCLES);  // bit-time counter width
    localparam int BIT_W      = $clog2(FRAME_BITS);  // bit index width

    localparam logic [2:0] FILL_BITS = 3'b111;  // low field of the status byte

    // status byte in IDLE with no event and no score
    localparam logic [7:0] STATUS_IDLE = {5'b00000, FILL_BITS};

endpackage

// ==== source/kick_resolver.sv ====
// kick_resolver
// Turns the kick strobe into a one-cycle round pulse tagged with the
// current role, plus a goal flag that is set when aim and dive differ.
// Kicks outside the SHOOTER and KEEPER roles are dropped.

`timescale 1ns/100ps

module kick_resolver (
    input  logic             clk,
    input  logic             rst,
    input  game_pkg::g_state game_state,
    input  logic             kick,
    input  logic [1:0]       aim,
    input  logic [1:0]       dive,
    output logic             round_done_gk,
    output logic             is_scored_gk,
    output logic             round_done_sh,
    output logic             is_scored_sh
);

    import game_pkg::*;

    logic kick_sh;   // kick taken while shooting
    logic kick_gk;   // kick faced while keeping
    logic goal;

    assign kick_sh = kick && (game_state == SHOOTER);
    assign kick_gk = kick && (game_state == KEEPER);
    assign goal    = (aim != dive);  // keeper guessed wrong

    always_ff @(posedge clk) begin
        if (rst) begin
            round_done_gk <= 1'b0;
            is_scored_gk  <= 1'b0;
            round_done_sh <= 1'b0;
            is_scored_sh  <= 1'b0;
        end else begin
            round_done_gk <= kick_gk;
            is_scored_gk  <= kick_gk && goal;  // enemy goal
            round_done_sh <= kick_sh;
            is_scored_sh  <= kick_sh && goal;  // our goal
        end
    end

endmodule

// ==== source/game_fsm.sv ====
// game_fsm
// Match sequencing. Alternates the local player between shooter and
// keeper, latches the play mode when a match starts, and parks in OVER
// once the score controller reports the end of the match.

`timescale 1ns/100ps

module game_fsm (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  game_pkg::g_mode  mode_sel,
    input  logic             round_done_gk,
    input  logic             round_done_sh,
    input  logic             shot_taken,
    input  logic             match_end,
    output game_pkg::g_state game_state,
    output game_pkg::g_mode  game_mode
);

    import game_pkg::*;

    g_state state_nxt;
    logic   keeper_done;

    // in MULTI the remote board decides when its kick is over
    assign keeper_done = (game_mode == MULTI) ? shot_taken : round_done_gk;

    always_comb begin
        state_nxt = game_state;
        case (game_state)
            IDLE: begin
                if (start) state_nxt = SHOOTER;  // local player opens
            end
            SHOOTER: begin
                if (match_end)          state_nxt = OVER;
                else if (round_done_sh) state_nxt = KEEPER;
            end
            KEEPER: begin
                if (match_end)        state_nxt = OVER;
                else if (keeper_done) state_nxt = SHOOTER;
            end
            OVER: begin
                if (start) state_nxt = IDLE;  // back to a clean table
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= IDLE;
            game_mode  <= SOLO;
        end else begin
            game_state <= state_nxt;
            if (game_state == IDLE && start) game_mode <= mode_sel;  // fixed per match
        end
    end

endmodule

// ==== source/score_control.sv ====
// score_control
// Keeps both scores for the match and decides its end. In SOLO the
// local resolver pulses drive both counters. In MULTI the enemy score
// is mirrored from the link and the local score counts remote saves
// and local goals. Also builds the status byte for the serial link.

`timescale 1ns/100ps

module score_control (
    input  logic                           clk,
    input  logic                           rst,
    input  game_pkg::g_state               game_state,
    input  logic                           is_scored_gk,
    input  logic                           is_scored_sh,
    input  logic                           round_done_gk,
    input  logic                           round_done_sh,
    input  logic                           is_scored,       // remote verdict
    input  game_pkg::g_mode                game_mode,
    input  logic                           shot_taken,      // remote kick strobe
    input  logic [game_pkg::SCORE_W-1:0]   opponent_score,
    output logic                           match_end,
    output logic                           match_result,    // 1 = player won
    output logic [game_pkg::SCORE_W-1:0]   score_player,
    output logic [game_pkg::SCORE_W-1:0]   score_enemy,
    output logic [7:0]                     data_to_transmit
);

    import game_pkg::*;
    import link_pkg::*;

    logic [SCORE_W-1:0] score_player_nxt;
    logic [SCORE_W-1:0] score_enemy_nxt;
    logic               match_end_nxt;
    logic               match_result_nxt;
    logic               event_flag;
    logic [7:0]         data_nxt;

    always_comb begin
        score_player_nxt = score_player;
        score_enemy_nxt  = score_enemy;
        case (game_state)
            IDLE: begin
                score_player_nxt = '0;
                score_enemy_nxt  = '0;
            end
            SHOOTER: begin
                if (game_mode == SOLO) begin
                    if (round_done_sh && is_scored_sh) score_player_nxt = score_player + 1'b1;
                end else begin
                    score_enemy_nxt = opponent_score;
                    // is_scored keeps the keeper-side naming, so low means our goal
                    if (round_done_sh && !is_scored) score_player_nxt = score_player + 1'b1;
                end
            end
            KEEPER: begin
                if (game_mode == SOLO) begin
                    if (round_done_gk && is_scored_gk) score_enemy_nxt = score_enemy + 1'b1;
                end else begin
                    score_enemy_nxt = opponent_score;
                    if (shot_taken && !is_scored) score_player_nxt = score_player + 1'b1; // save
                end
            end
            default: ;  // OVER keeps the final score
        endcase
    end

    // end of match is taken from the registered scores
    always_comb begin
        if (game_state == IDLE) begin
            match_end_nxt    = 1'b0;
            match_result_nxt = 1'b0;
        end else if (score_player == WIN_SCORE) begin
            match_end_nxt    = 1'b1;
            match_result_nxt = 1'b1;
        end else if (score_enemy == WIN_SCORE) begin
            match_end_nxt    = 1'b1;
            match_result_nxt = 1'b0;
        end else begin
            match_end_nxt    = 1'b0;
            match_result_nxt = 1'b0;
        end
    end

    always_comb begin
        case (game_state)
            KEEPER:  event_flag = round_done_gk;  // our dive finished
            SHOOTER: event_flag = shot_taken;
            default: event_flag = 1'b0;
        endcase
    end

    assign data_nxt = {event_flag, is_scored, score_player, FILL_BITS};

    always_ff @(posedge clk) begin
        if (rst) begin
            score_player     <= '0;
            score_enemy      <= '0;
            match_end        <= 1'b0;
            match_result     <= 1'b0;
            data_to_transmit <= STATUS_IDLE;
        end else begin
            score_player     <= score_player_nxt;
            score_enemy      <= score_enemy_nxt;
            match_end        <= match_end_nxt;
            match_result     <= match_result_nxt;
            data_to_transmit <= data_nxt;
        end
    end

endmodule

// ==== source/link_tx.sv ====
// link_tx
// Serial transmitter for the status byte, 8N1, LSB first.
// A frame starts when the byte differs from the last one sent and the
// line is idle. Changes during a frame collapse into the latest value.

`timescale 1ns/100ps

module link_tx (
    input  logic       clk,
    input  logic       rst,
    input  logic [7:0] data_to_transmit,
    output logic       tx,
    output logic       tx_busy
);

    import link_pkg::*;

    logic [7:0]            last_sent;
    logic [FRAME_BITS-1:0] frame;     // shifts out from bit 0
    logic [CYC_W-1:0]      cyc_cnt;   // clocks within a bit
    logic [BIT_W-1:0]      bit_cnt;   // bit within the frame

    assign tx = frame[0];  // all ones when idle

    always_ff @(posedge clk) begin
        if (rst) begin
            last_sent <= STATUS_IDLE;
            frame     <= '1;
            cyc_cnt   <= '0;
            bit_cnt   <= '0;
            tx_busy   <= 1'b0;
        end else if (!tx_busy) begin
            if (data_to_transmit != last_sent) begin
                last_sent <= data_to_transmit;
                frame     <= {1'b1, data_to_transmit, 1'b0};  // stop, data, start
                cyc_cnt   <= '0;
                bit_cnt   <= '0;
                tx_busy   <= 1'b1;
            end
        end else if (cyc_cnt == CYC_W'(BIT_CYCLES - 1)) begin
            cyc_cnt <= '0;
            frame   <= {1'b1, frame[FRAME_BITS-1:1]};  // refill with idle level
            if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
                tx_busy <= 1'b0;  // stop bit done
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
        end
    end

endmodule

// ==== source/shootout_top.sv ====
// shootout_top
// Match logic of the penalty shootout: kick resolver, role FSM,
// score controller and the serial link transmitter to the other board.

`timescale 1ns/100ps

module shootout_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          start,
    input  game_pkg::g_mode               mode_sel,
    input  logic                          kick,
    input  logic [1:0]                    aim,
    input  logic [1:0]                    dive,
    input  logic                          remote_shot,     // remote kick strobe
    input  logic                          remote_scored,   // remote goal verdict
    input  logic [game_pkg::SCORE_W-1:0]  opponent_score,
    output game_pkg::g_state              game_state,
    output logic [game_pkg::SCORE_W-1:0]  score_player,
    output logic [game_pkg::SCORE_W-1:0]  score_enemy,
    output logic                          match_end,
    output logic                          match_result,
    output logic                          tx,
    output logic                          tx_busy
);

    game_pkg::g_mode game_mode;
    logic            round_done_gk;
    logic            round_done_sh;
    logic            is_scored_gk;
    logic            is_scored_sh;
    logic [7:0]      data_to_transmit;

    kick_resolver kick_resolver_inst (
        .clk, .rst, .game_state, .kick, .aim, .dive,
        .round_done_gk, .is_scored_gk, .round_done_sh, .is_scored_sh
    );

    game_fsm game_fsm_inst (
        .clk, .rst, .start, .mode_sel, .round_done_gk, .round_done_sh,
        .shot_taken (remote_shot), .match_end, .game_state, .game_mode
    );

    score_control score_control_inst (
        .clk, .rst, .game_state, .is_scored_gk, .is_scored_sh,
        .round_done_gk, .round_done_sh, .is_scored (remote_scored),
        .game_mode, .shot_taken (remote_shot), .opponent_score,
        .match_end, .match_result, .score_player, .score_enemy, .data_to_transmit
    );

    link_tx link_tx_inst (.clk, .rst, .data_to_transmit, .tx, .tx_busy);

endmodule

// ==== dv/shootout_tb.sv ====
// shootout_tb
// Testbench for the penalty shootout match logic. Plays a SOLO match
// to its end against a reference score model, runs MULTI rounds with
// remote kicks, and decodes every frame that appears on tx.

`timescale 1ns/100ps

module shootout_tb;

    import game_pkg::*;
    import link_pkg::*;

    localparam int KICK_GAP   = 8;     // idle cycles after each round
    localparam int MAX_ROUNDS = 40;
    localparam int TIMEOUT    = 4000;  // rounds, frame drains and margin
    localparam int T_RST = 0, T_SHOOT = 1, T_KEEP = 2, T_END = 3, T_MULTI = 4, T_TX = 5;

    logic               clk, rst, start, kick, remote_shot, remote_scored;
    logic               match_end, match_result, tx, tx_busy;
    logic [1:0]         aim, dive;
    logic [SCORE_W-1:0] opponent_score, score_player, score_enemy;
    g_mode              mode_sel;
    g_state             game_state, model_state;
    int                 model_player, model_enemy, rounds;
    logic [SCORE_W-1:0] score_d1, score_d2, opp_q;  // delayed copies for the checkers
    logic               in_multi, live_q, frame_active;
    int                 errs [6];
    int                 cycles, frames, passed, failed;

    shootout_top shootout_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles   <= cycles + 1;
        score_d1 <= score_player;
        score_d2 <= score_d1;
        opp_q    <= opponent_score;
        live_q   <= in_multi && (game_state == SHOOTER || game_state == KEEPER);
        if (cycles >= TIMEOUT) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic void check_val(input int id, input string name,
                                      input int got, input int exp);
        assert (got == exp)
        else begin
            errs[id]++;
            $display("Fail %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endfunction

    task automatic report_test(input int id, input string name);
        if (errs[id] == 0) begin
            passed++;
            $display("pass  %s", name);
        end else begin
            failed++;
            $display("fail  %s: %0d failed checks", name, errs[id]);
        end
    endtask

    task automatic pulse_start(input g_mode m);
        @(posedge clk);
        start    <= 1'b1;
        mode_sel <= m;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
    endtask

    task automatic wait_link_idle();
        int quiet;
        quiet = 0;
        while (quiet < 3) begin
            @(negedge clk);
            quiet = (tx_busy || frame_active) ? 0 : quiet + 1;
        end
    endtask

    // one local kick in SOLO, checked against the score model
    task automatic play_round();
        logic [1:0] a;
        logic [1:0] d;
        int         id;
        a  = 2'($urandom);
        d  = 2'($urandom);
        if (rounds < 2) d = a;  // open with one save in each role
        id = (model_state == SHOOTER) ? T_SHOOT : T_KEEP;
        @(posedge clk);
        kick <= 1'b1;
        aim  <= a;
        dive <= d;
        @(posedge clk);
        kick <= 1'b0;
        @(negedge clk);  // scores not yet moved in the round pulse cycle
        check_val(id, "score_player", score_player, model_player);
        check_val(id, "score_enemy", score_enemy, model_enemy);
        if (a != d && id == T_SHOOT) model_player++;
        if (a != d && id == T_KEEP) model_enemy++;
        model_state = (id == T_SHOOT) ? KEEPER : SHOOTER;
        @(negedge clk);
        check_val(id, "score_player", score_player, model_player);
        check_val(id, "score_enemy", score_enemy, model_enemy);
        check_val(id, "game_state", game_state, model_state);
        if (model_player == WIN_SCORE || model_enemy == WIN_SCORE) begin
            @(negedge clk);
            check_val(T_END, "match_end", match_end, 1);
            check_val(T_END, "match_result", match_result, model_player == WIN_SCORE);
            @(negedge clk);
            model_state = OVER;
            check_val(T_END, "game_state", game_state, model_state);
        end
        repeat (KICK_GAP) @(negedge clk);
    endtask

    // MULTI round with a local shot and then a remote kick faced as keeper
    task automatic multi_round(input logic remote_verdict);
        logic v;
        v = 1'($urandom);
        @(posedge clk);
        opponent_score <= 3'($urandom_range(4, 0));
        kick           <= 1'b1;
        aim            <= 2'($urandom);
        dive           <= 2'($urandom);
        remote_scored  <= v;
        @(posedge clk);
        kick <= 1'b0;
        repeat (2) @(negedge clk);
        if (!v) model_player++;
        check_val(T_MULTI, "score_player", score_player, model_player);
        check_val(T_MULTI, "game_state", game_state, KEEPER);
        repeat (KICK_GAP) @(negedge clk);
        v = remote_verdict;
        @(posedge clk);
        remote_shot   <= 1'b1;
        remote_scored <= v;
        @(posedge clk);
        remote_shot <= 1'b0;
        @(negedge clk);
        if (!v) model_player++;  // local keeper saved it
        check_val(T_MULTI, "score_player", score_player, model_player);
        check_val(T_MULTI, "game_state", game_state, SHOOTER);
        repeat (KICK_GAP) @(negedge clk);
    endtask

    // enemy score mirrors the link one edge later while in play
    assert property (@(posedge clk) live_q |-> score_enemy == opp_q)
    else begin
        errs[T_MULTI]++;
        $display("Fail score_enemy: got 0x%0h, expected 0x%0h",
                 $sampled(score_enemy), $sampled(opp_q));
    end

    // frame decoder sampling tx at bit centres
    initial begin
        logic [FRAME_BITS-1:0] bits;
        logic [SCORE_W-1:0]    exp_score;
        frame_active = 1'b0;
        wait (rst === 1'b0);
        forever begin
            @(negedge tx);
            frame_active = 1'b1;
            @(negedge clk);
            exp_score = score_d2;  // score when the byte was registered
            repeat (BIT_CYCLES / 2) @(negedge clk);
            for (int i = 0; i < FRAME_BITS; i++) begin
                bits[i] = tx;
                if (i < FRAME_BITS - 1) repeat (BIT_CYCLES) @(negedge clk);
            end
            check_val(T_TX, "tx start bit", bits[0], 0);
            check_val(T_TX, "tx stop bit", bits[FRAME_BITS-1], 1);
            check_val(T_TX, "tx fill bits", bits[3:1], FILL_BITS);
            check_val(T_TX, "tx score field", bits[6:4], exp_score);
            frames++;
            frame_active = 1'b0;
        end
    end

    initial begin
        rst            = 1'b1;
        start          = 1'b0;
        mode_sel       = SOLO;
        kick           = 1'b0;
        aim            = 2'b00;
        dive           = 2'b00;
        remote_shot    = 1'b0;
        remote_scored  = 1'b0;
        opponent_score = '0;
        in_multi       = 1'b0;
        void'($urandom(32'ha4d1));
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val(T_RST, "game_state", game_state, IDLE);
        check_val(T_RST, "score_player", score_player, 0);
        check_val(T_RST, "score_enemy", score_enemy, 0);
        check_val(T_RST, "match_end", match_end, 0);
        check_val(T_RST, "tx", tx, 1);
        repeat (2 * BIT_CYCLES) begin
            @(negedge clk);
            check_val(T_RST, "tx_busy", tx_busy, 0);
        end
        report_test(T_RST, "reset state and quiet link");

        pulse_start(SOLO);
        check_val(T_SHOOT, "game_state", game_state, SHOOTER);
        model_player = 0;
        model_enemy  = 0;
        model_state  = SHOOTER;
        rounds       = 0;
        while (model_state != OVER && rounds < MAX_ROUNDS) begin
            play_round();
            rounds++;
        end
        if (model_state != OVER) begin
            errs[T_END]++;
            $display("The SOLO match did not end within %0d rounds", MAX_ROUNDS);
        end
        report_test(T_SHOOT, "solo shooter rounds");
        report_test(T_KEEP, "solo keeper rounds");
        @(posedge clk);
        kick <= 1'b1;  // ignored in OVER
        @(posedge clk);
        kick <= 1'b0;
        repeat (4) @(negedge clk);
        check_val(T_END, "score_player", score_player, model_player);
        check_val(T_END, "score_enemy", score_enemy, model_enemy);
        check_val(T_END, "game_state", game_state, OVER);
        pulse_start(SOLO);
        check_val(T_END, "game_state", game_state, IDLE);
        @(negedge clk);
        check_val(T_END, "score_player", score_player, 0);
        check_val(T_END, "score_enemy", score_enemy, 0);
        check_val(T_END, "match_end", match_end, 0);
        report_test(T_END, "match end, hold in OVER and restart");

        pulse_start(MULTI);
        in_multi     = 1'b1;
        model_player = 0;
        multi_round(1'b0);  // remote kick saved
        multi_round(1'b1);  // remote kick scored
        wait_link_idle();
        in_multi = 1'b0;
        @(negedge clk);
        report_test(T_MULTI, "multi mode scoring");
        if (frames == 0) begin
            errs[T_TX]++;
            $display("No frame was seen on tx");
        end
        report_test(T_TX, "serial frames");
        $display("Tests: %0d passed, %0d failed, %0d frames decoded", passed, failed, frames);
        if (failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== all.f ====
source/game_pkg.sv
source/link_pkg.sv
source/kick_resolver.sv
source/game_fsm.sv
source/score_control.sv
source/link_tx.sv
source/shootout_top.sv
dv/shootout_tb.sv

// ==== Makefile ====
# Verilator build and run of the shootout testbench
TOP = shootout_tb

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Regression failed" sim.log; then exit 1; fi
	@grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
